// File: include/soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// bus geometry
`define SOC_AW        32
`define SOC_DW        128
`define SOC_SW        16
`define PERIPH_DW     64

// L2 scratch memory, 256 words of 16 bytes
`define L2_BASE       32'h1C00_0000
`define L2_WORDS      256

// peripheral window, four 64-bit registers
`define PERIPH_BASE   32'h1A10_0000
`define PERIPH_BYTES  32

// external window runs up to the top of the address space
`define EXT_BASE      32'h8000_0000

// cluster control
`define N_CLUSTERS    4
`define SOC_ID        64'h5055_4C50_0001_0004

`endif

// File: design/soc_pkg.sv
`default_nettype none

`include "soc_config.svh"

package soc_pkg;

  // one single-beat request from the host
  typedef struct packed {
    logic [`SOC_AW-1:0] addr;
    logic               we;
    logic [`SOC_DW-1:0] wdata;
    logic [`SOC_SW-1:0] strb;
  } soc_req_t;

  // one response, err marks a decode or slave error
  typedef struct packed {
    logic [`SOC_DW-1:0] rdata;
    logic               err;
  } soc_rsp_t;

  // a bus word seen whole or as two peripheral lanes
  // lane[1] holds the upper eight bytes, selected by address bit 3
  typedef union packed {
    logic [`SOC_DW-1:0]            word;
    logic [1:0][`PERIPH_DW-1:0]    lane;
  } bus_word_u;

  // decoded destination of a request
  typedef enum logic [1:0] {
    ROUTE_L2,
    ROUTE_PERIPH,
    ROUTE_EXT,
    ROUTE_ERR
  } route_e;

endpackage

`default_nettype wire

// File: design/soc_bus.sv
`default_nettype none

`include "soc_config.svh"

module soc_bus
  import soc_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               rst_i,

  // host side
  input  wire soc_req_t           host_req_i,
  input  wire logic               host_req_valid_i,
  output      logic               host_req_ready_o,
  output      soc_rsp_t           host_rsp_o,
  output      logic               host_rsp_valid_o,
  input  wire logic               host_rsp_ready_i,

  // target requests
  output      soc_req_t           l2_req_o,
  output      logic               l2_stb_o,
  output      soc_req_t           periph_req_o,
  output      logic               periph_stb_o,
  output      soc_req_t           ext_fwd_req_o,
  output      logic               ext_fwd_stb_o,

  // target responses
  input  wire logic [`SOC_DW-1:0] l2_rdata_i,
  input  wire logic [`SOC_DW-1:0] periph_rdata_i,
  input  wire soc_rsp_t           ext_rsp_i,
  input  wire logic               ext_done_i
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ACCESS,
    S_RESP
  } state_e;

  // window ends are exclusive
  localparam logic [`SOC_AW-1:0] L2_END     = `L2_BASE + `L2_WORDS * `SOC_SW;
  localparam logic [`SOC_AW-1:0] PERIPH_END = `PERIPH_BASE + `PERIPH_BYTES;

  state_e   state_q;
  route_e   route_q;
  route_e   route_d;
  soc_req_t req_q;
  soc_rsp_t rsp_d;
  soc_rsp_t rsp_q;
  logic     issue_q;
  logic     accept;
  logic     capture;
  logic     l2_stb_q;
  logic     periph_stb_q;
  logic     ext_stb_q;

  function automatic route_e decode(input logic [`SOC_AW-1:0] addr);
    route_e r;
    if (addr >= `L2_BASE && addr < L2_END) begin
      r = ROUTE_L2;
    end else if (addr >= `PERIPH_BASE && addr < PERIPH_END) begin
      r = ROUTE_PERIPH;
    end else if (addr >= `EXT_BASE) begin
      r = ROUTE_EXT;
    end else begin
      r = ROUTE_ERR;
    end
    return r;
  endfunction

  assign route_d          = decode(host_req_i.addr);
  assign host_req_ready_o = (state_q == S_IDLE);
  assign accept           = host_req_valid_i && host_req_ready_o;

  // internal targets answer one cycle after the strobe,
  // the external port signals its own completion
  assign capture = (state_q == S_ACCESS) &&
                   ((route_q == ROUTE_EXT) ? ext_done_i : !issue_q);

  always_comb begin
    rsp_d = '0;
    case (route_q)
      ROUTE_L2:     rsp_d.rdata = l2_rdata_i;
      ROUTE_PERIPH: rsp_d.rdata = periph_rdata_i;
      ROUTE_EXT:    rsp_d = ext_rsp_i;
      default:      rsp_d.err = 1'b1;
    endcase
    // write responses from internal targets carry no data
    if (req_q.we && route_q != ROUTE_EXT) begin
      rsp_d.rdata = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= S_IDLE;
      route_q      <= ROUTE_ERR;
      issue_q      <= 1'b0;
      l2_stb_q     <= 1'b0;
      periph_stb_q <= 1'b0;
      ext_stb_q    <= 1'b0;
    end else begin
      issue_q      <= accept;
      l2_stb_q     <= accept && (route_d == ROUTE_L2);
      periph_stb_q <= accept && (route_d == ROUTE_PERIPH);
      ext_stb_q    <= accept && (route_d == ROUTE_EXT);
      case (state_q)
        S_IDLE: begin
          if (accept) begin
            state_q <= S_ACCESS;
            route_q <= route_d;
          end
        end
        S_ACCESS: begin
          if (capture) begin
            state_q <= S_RESP;
          end
        end
        S_RESP: begin
          if (host_rsp_ready_i) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // request and response payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= host_req_i;
    end
    if (capture) begin
      rsp_q <= rsp_d;
    end
  end

  assign l2_req_o         = req_q;
  assign periph_req_o     = req_q;
  assign ext_fwd_req_o    = req_q;
  assign l2_stb_o         = l2_stb_q;
  assign periph_stb_o     = periph_stb_q;
  assign ext_fwd_stb_o    = ext_stb_q;
  assign host_rsp_o       = rsp_q;
  assign host_rsp_valid_o = (state_q == S_RESP);

endmodule

`default_nettype wire

// File: design/l2_mem.sv
`default_nettype none

`include "soc_config.svh"

module l2_mem
  import soc_pkg::*;
#(
  parameter int unsigned DEPTH = `L2_WORDS
) (
  input  wire logic               clk_i,
  input  wire soc_req_t           req_i,
  input  wire logic               stb_i,
  output      logic [`SOC_DW-1:0] rdata_o
);

  localparam int unsigned IDX_W = $clog2(DEPTH);
  localparam int unsigned OFS_W = $clog2(`SOC_SW);

  logic [`SOC_DW-1:0] mem_q [DEPTH];
  logic [IDX_W-1:0]   idx;

  // word index above the byte offset, wraps modulo DEPTH
  assign idx = req_i.addr[OFS_W +: IDX_W];

  always_ff @(posedge clk_i) begin
    if (stb_i) begin
      if (req_i.we) begin
        for (int b = 0; b < `SOC_SW; b++) begin
          if (req_i.strb[b]) begin
            mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/soc_periph.sv
`default_nettype none

`include "soc_config.svh"

module soc_periph
  import soc_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire soc_req_t               req_i,
  input  wire logic                   stb_i,
  output      logic [`SOC_DW-1:0]     rdata_o,
  output      logic [`N_CLUSTERS-1:0] cl_fetch_en_o,
  input  wire logic [`N_CLUSTERS-1:0] cl_eoc_i
);

  localparam int unsigned LANE_SW = `PERIPH_DW / 8;
  localparam int unsigned PAD_W   = `PERIPH_DW - `N_CLUSTERS;

  bus_word_u              wr_word;
  bus_word_u              rd_word;
  logic                   lane_sel;
  logic [1:0]             reg_sel;
  logic [`PERIPH_DW-1:0]  wr_lane;
  logic [LANE_SW-1:0]     wr_strb;
  logic [`PERIPH_DW-1:0]  reg_rdata;
  logic [`PERIPH_DW-1:0]  scratch_q;
  logic [`N_CLUSTERS-1:0] fetch_en_q;

  // 128 to 64 lane selection
  assign lane_sel     = req_i.addr[3];
  assign reg_sel      = req_i.addr[4:3];
  assign wr_word.word = req_i.wdata;
  assign wr_lane      = wr_word.lane[lane_sel];
  assign wr_strb      = req_i.strb[LANE_SW*lane_sel +: LANE_SW];

  always_comb begin
    case (reg_sel)
      2'd0:    reg_rdata = `SOC_ID;
      2'd1:    reg_rdata = scratch_q;
      2'd2:    reg_rdata = {{PAD_W{1'b0}}, fetch_en_q};
      default: reg_rdata = {{PAD_W{1'b0}}, cl_eoc_i};
    endcase
    // unselected lane reads zero
    rd_word                = '0;
    rd_word.lane[lane_sel] = reg_rdata;
  end

  // ID and status ignore writes
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      scratch_q  <= '0;
      fetch_en_q <= '0;
    end else if (stb_i && req_i.we) begin
      if (reg_sel == 2'd1) begin
        for (int b = 0; b < LANE_SW; b++) begin
          if (wr_strb[b]) begin
            scratch_q[8*b +: 8] <= wr_lane[8*b +: 8];
          end
        end
      end
      // enables live in the lowest byte
      if (reg_sel == 2'd2 && wr_strb[0]) begin
        fetch_en_q <= wr_lane[`N_CLUSTERS-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (stb_i && !req_i.we) begin
      rdata_o <= rd_word.word;
    end
  end

  assign cl_fetch_en_o = fetch_en_q;

endmodule

`default_nettype wire

// File: design/ext_mst_port.sv
`default_nettype none

`include "soc_config.svh"

module ext_mst_port
  import soc_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_i,

  // forwarded from the SoC bus
  input  wire soc_req_t fwd_req_i,
  input  wire logic     fwd_stb_i,

  // external master port
  output      soc_req_t ext_req_o,
  output      logic     ext_req_valid_o,
  input  wire logic     ext_req_ready_i,
  input  wire soc_rsp_t ext_rsp_i,
  input  wire logic     ext_rsp_valid_i,
  output      logic     ext_rsp_ready_o,

  // back to the SoC bus
  output      soc_rsp_t ext_rsp_o,
  output      logic     ext_done_o
);

  typedef enum logic [1:0] {
    P_IDLE,
    P_REQ,
    P_RSP
  } port_state_e;

  port_state_e state_q;
  soc_req_t    req_q;
  soc_rsp_t    rsp_q;
  logic        done_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= P_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        P_IDLE: begin
          if (fwd_stb_i) begin
            state_q <= P_REQ;
          end
        end
        P_REQ: begin
          if (ext_req_ready_i) begin
            state_q <= P_RSP;
          end
        end
        P_RSP: begin
          // no timeout, the slave may take as long as it likes
          if (ext_rsp_valid_i) begin
            state_q <= P_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= P_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (fwd_stb_i) begin
      req_q <= fwd_req_i;
    end
    if (state_q == P_RSP && ext_rsp_valid_i) begin
      rsp_q <= ext_rsp_i;
    end
  end

  assign ext_req_o       = req_q;
  assign ext_req_valid_o = (state_q == P_REQ);
  assign ext_rsp_ready_o = (state_q == P_RSP);
  assign ext_rsp_o       = rsp_q;
  assign ext_done_o      = done_q;

endmodule

`default_nettype wire

// File: design/pulp_soc.sv
`default_nettype none

`include "soc_config.svh"

module pulp_soc
  import soc_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,

  // host master
  input  wire soc_req_t               host_req_i,
  input  wire logic                   host_req_valid_i,
  output      logic                   host_req_ready_o,
  output      soc_rsp_t               host_rsp_o,
  output      logic                   host_rsp_valid_o,
  input  wire logic                   host_rsp_ready_i,

  // external window
  output      soc_req_t               ext_req_o,
  output      logic                   ext_req_valid_o,
  input  wire logic                   ext_req_ready_i,
  input  wire soc_rsp_t               ext_rsp_i,
  input  wire logic                   ext_rsp_valid_i,
  output      logic                   ext_rsp_ready_o,

  // cluster control
  output      logic [`N_CLUSTERS-1:0] cl_fetch_en_o,
  input  wire logic [`N_CLUSTERS-1:0] cl_eoc_i
);

  soc_req_t           l2_req;
  logic               l2_stb;
  logic [`SOC_DW-1:0] l2_rdata;
  soc_req_t           periph_req;
  logic               periph_stb;
  logic [`SOC_DW-1:0] periph_rdata;
  soc_req_t           ext_fwd_req;
  logic               ext_fwd_stb;
  soc_rsp_t           ext_rsp;
  logic               ext_done;

  soc_bus i_soc_bus (
    .clk_i,
    .rst_i,
    .host_req_i,
    .host_req_valid_i,
    .host_req_ready_o,
    .host_rsp_o,
    .host_rsp_valid_o,
    .host_rsp_ready_i,
    .l2_req_o       (l2_req),
    .l2_stb_o       (l2_stb),
    .periph_req_o   (periph_req),
    .periph_stb_o   (periph_stb),
    .ext_fwd_req_o  (ext_fwd_req),
    .ext_fwd_stb_o  (ext_fwd_stb),
    .l2_rdata_i     (l2_rdata),
    .periph_rdata_i (periph_rdata),
    .ext_rsp_i      (ext_rsp),
    .ext_done_i     (ext_done)
  );

  l2_mem #(
    .DEPTH (`L2_WORDS)
  ) i_l2_mem (
    .clk_i,
    .req_i   (l2_req),
    .stb_i   (l2_stb),
    .rdata_o (l2_rdata)
  );

  soc_periph i_periphs (
    .clk_i,
    .rst_i,
    .req_i   (periph_req),
    .stb_i   (periph_stb),
    .rdata_o (periph_rdata),
    .cl_fetch_en_o,
    .cl_eoc_i
  );

  ext_mst_port i_ext_port (
    .clk_i,
    .rst_i,
    .fwd_req_i  (ext_fwd_req),
    .fwd_stb_i  (ext_fwd_stb),
    .ext_req_o,
    .ext_req_valid_o,
    .ext_req_ready_i,
    .ext_rsp_i,
    .ext_rsp_valid_i,
    .ext_rsp_ready_o,
    .ext_rsp_o  (ext_rsp),
    .ext_done_o (ext_done)
  );

endmodule

`default_nettype wire

// File: bench/pulp_soc_sva.sv
`default_nettype none

`include "soc_config.svh"

module pulp_soc_sva
  import soc_pkg::*;
(
  input wire logic                   clk_i,
  input wire logic                   rst_i,
  input wire soc_req_t               host_req_i,
  input wire logic                   host_req_valid_i,
  input wire logic                   host_req_ready_o,
  input wire soc_rsp_t               host_rsp_o,
  input wire logic                   host_rsp_valid_o,
  input wire logic                   host_rsp_ready_i,
  input wire soc_req_t               ext_req_o,
  input wire logic                   ext_req_valid_o,
  input wire logic                   ext_req_ready_i,
  input wire logic                   ext_rsp_ready_o,
  input wire logic [`N_CLUSTERS-1:0] cl_fetch_en_o
);

  int unsigned fails = 0;
  logic        accept_local;

  // only the external window has a variable latency
  assign accept_local = host_req_valid_i && host_req_ready_o &&
                        (host_req_i.addr < `EXT_BASE);

  reset_idle: assert property (@(posedge clk_i) rst_i |=>
      (!host_rsp_valid_o && !ext_req_valid_o && !ext_rsp_ready_o &&
       cl_fetch_en_o == '0 && host_req_ready_o))
    else begin
      $error("control outputs active after reset");
      fails++;
    end

  rsp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      host_rsp_valid_o && !host_rsp_ready_i |=> host_rsp_valid_o && $stable(host_rsp_o))
    else begin
      $error("host response changed under back-pressure");
      fails++;
    end

  ext_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      ext_req_valid_o && !ext_req_ready_i |=> ext_req_valid_o && $stable(ext_req_o))
    else begin
      $error("external request changed before acceptance");
      fails++;
    end

  local_latency: assert property (@(posedge clk_i) disable iff (rst_i)
      accept_local |=> !host_rsp_valid_o ##1 !host_rsp_valid_o ##1 host_rsp_valid_o)
    else begin
      $error("local response latency is not two cycles");
      fails++;
    end

endmodule

bind pulp_soc pulp_soc_sva i_sva (.*);

`default_nettype wire

// File: bench/tb_pulp_soc.sv
`default_nettype none

`include "soc_config.svh"

module tb_pulp_soc
  import soc_pkg::*;
();

  localparam int TIMEOUT = 200;
  localparam int N_L2    = 16;

  logic                   clk_i;
  logic                   rst_i;
  soc_req_t               host_req_i;
  logic                   host_req_valid_i;
  logic                   host_req_ready_o;
  soc_rsp_t               host_rsp_o;
  logic                   host_rsp_valid_o;
  logic                   host_rsp_ready_i;
  soc_req_t               ext_req_o;
  logic                   ext_req_valid_o;
  logic                   ext_req_ready_i = 1'b0;
  soc_rsp_t               ext_rsp_i = '0;
  logic                   ext_rsp_valid_i = 1'b0;
  logic                   ext_rsp_ready_o;
  logic [`N_CLUSTERS-1:0] cl_fetch_en_o;
  logic [`N_CLUSTERS-1:0] cl_eoc_i;

  integer                 seed;
  int                     errors;
  logic [`SOC_DW-1:0]     l2_ref [N_L2];
  logic [`PERIPH_DW-1:0]  scratch_ref;
  logic [`N_CLUSTERS-1:0] fetch_ref;
  soc_req_t               exp_ext_req;
  int                     ext_state;
  int                     ext_cnt;

  pulp_soc dut0 (.*);

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  function automatic soc_rsp_t ext_rule(input logic [`SOC_AW-1:0] a);
    soc_rsp_t r;
    r.rdata = ~{4{a}};
    r.err   = a[2];
    return r;
  endfunction

  function automatic logic [`SOC_DW-1:0] rand_word();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("sim failed");
    $finish;
  endtask

  task automatic expect_rsp(input soc_rsp_t got, input soc_rsp_t exp, input string what);
    assert (got === exp) else begin
      errors++;
      $display("FAILED %0t: %s got %h/%b expected %h/%b", $time, what,
               got.rdata, got.err, exp.rdata, exp.err);
    end
  endtask

  // one host transfer, random stalls on the response side
  // handshakes are sampled at the falling edge
  task automatic transact(input logic [`SOC_AW-1:0] addr, input logic we,
                          input logic [`SOC_DW-1:0] wdata, input logic [`SOC_SW-1:0] strb,
                          output soc_rsp_t rsp);
    int   n;
    logic hs;
    n  = 0;
    hs = 1'b0;
    host_req_i       <= '{addr: addr, we: we, wdata: wdata, strb: strb};
    host_req_valid_i <= 1'b1;
    do begin
      @(negedge clk_i);
      hs = host_req_ready_o;
      @(posedge clk_i);
      n++;
    end while (!hs && n < TIMEOUT);
    if (!hs) begin
      abort_run("host request never accepted");
    end else begin
      host_req_valid_i <= 1'b0;
      n  = 0;
      hs = 1'b0;
      do begin
        host_rsp_ready_i <= (($random(seed) & 3) != 0);
        @(negedge clk_i);
        hs  = host_rsp_valid_o && host_rsp_ready_i;
        rsp = host_rsp_o;
        @(posedge clk_i);
        n++;
      end while (!hs && n < TIMEOUT);
      host_rsp_ready_i <= 1'b0;
      if (!hs) begin
        abort_run("host response never completed");
      end
    end
  endtask

  // external slave model, random accept and answer delays
  always @(posedge clk_i) begin
    if (rst_i) begin
      ext_req_ready_i <= 1'b0;
      ext_rsp_valid_i <= 1'b0;
      ext_rsp_i       <= '0;
      ext_state       <= 0;
      ext_cnt         <= 0;
    end else begin
      // port waits for the response only after its request was taken
      assert (ext_rsp_ready_o === (ext_state >= 3)) else begin
        errors++;
        $display("FAILED %0t: ext_rsp_ready_o %b expected %b", $time,
                 ext_rsp_ready_o, (ext_state >= 3));
      end
      case (ext_state)
        0: if (ext_req_valid_o) begin
          ext_cnt   <= $random(seed) & 7;
          ext_state <= 1;
        end
        1: if (ext_cnt == 0) begin
          ext_req_ready_i <= 1'b1;
          ext_state       <= 2;
        end else begin
          ext_cnt <= ext_cnt - 1;
        end
        2: begin
          assert (ext_req_o === exp_ext_req) else begin
            errors++;
            $display("FAILED %0t: external request %h differs from host request",
                     $time, ext_req_o.addr);
          end
          ext_req_ready_i <= 1'b0;
          ext_rsp_i       <= ext_rule(ext_req_o.addr);
          ext_cnt         <= $random(seed) & 7;
          ext_state       <= 3;
        end
        3: if (ext_cnt == 0) begin
          ext_rsp_valid_i <= 1'b1;
          ext_state       <= 4;
        end else begin
          ext_cnt <= ext_cnt - 1;
        end
        default: if (ext_rsp_ready_o) begin
          ext_rsp_valid_i <= 1'b0;
          ext_state       <= 0;
        end
      endcase
    end
  end

  initial begin
    soc_rsp_t           rsp;
    bus_word_u          lane_word;
    logic [`SOC_DW-1:0] wdata;
    logic [`SOC_SW-1:0] strb;
    logic [`SOC_AW-1:0] addr;
    int                 idx;
    seed             = 32'h9061;
    errors           = 0;
    rst_i            = 1'b1;
    host_req_i       = '0;
    host_req_valid_i = 1'b0;
    host_rsp_ready_i = 1'b0;
    cl_eoc_i         = '0;
    exp_ext_req      = '0;
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    assert (!host_rsp_valid_o && !ext_req_valid_o && cl_fetch_en_o == '0 && host_req_ready_o)
      else begin
        errors++;
        $display("FAILED %0t: outputs not idle after reset", $time);
      end
    @(posedge clk_i);

    // L2 fill, then strobed overwrites, then read back
    for (int i = 0; i < N_L2; i++) begin
      l2_ref[i] = rand_word();
      transact(`L2_BASE + i * 16, 1'b1, l2_ref[i], '1, rsp);
      expect_rsp(rsp, '{rdata: '0, err: 1'b0}, "L2 write");
    end
    for (int i = 0; i < 24; i++) begin
      idx   = $random(seed) & (N_L2 - 1);
      wdata = rand_word();
      strb  = $random(seed);
      for (int b = 0; b < `SOC_SW; b++) begin
        if (strb[b]) l2_ref[idx][8*b +: 8] = wdata[8*b +: 8];
      end
      transact(`L2_BASE + idx * 16, 1'b1, wdata, strb, rsp);
    end
    for (int i = 0; i < N_L2; i++) begin
      transact(`L2_BASE + i * 16, 1'b0, '0, '0, rsp);
      expect_rsp(rsp, '{rdata: l2_ref[i], err: 1'b0}, "L2 read");
    end

    // peripheral registers
    transact(`PERIPH_BASE, 1'b0, '0, '0, rsp);
    lane_word.word    = '0;
    lane_word.lane[0] = `SOC_ID;
    expect_rsp(rsp, '{rdata: lane_word.word, err: 1'b0}, "ID read");
    scratch_ref = '0;
    for (int i = 0; i < 4; i++) begin
      wdata = rand_word();
      strb  = $random(seed);
      for (int b = 0; b < 8; b++) begin
        if (strb[8 + b]) scratch_ref[8*b +: 8] = wdata[64 + 8*b +: 8];
      end
      transact(`PERIPH_BASE + 8, 1'b1, wdata, strb, rsp);
      transact(`PERIPH_BASE + 8, 1'b0, '0, '0, rsp);
      lane_word.word    = '0;
      lane_word.lane[1] = scratch_ref;
      expect_rsp(rsp, '{rdata: lane_word.word, err: 1'b0}, "scratch read");
    end
    wdata = rand_word();
    for (int i = 0; i < 2; i++) begin
      fetch_ref = wdata[`N_CLUSTERS-1:0];
      transact(`PERIPH_BASE + 16, 1'b1, wdata, '1, rsp);
      assert (cl_fetch_en_o === fetch_ref) else begin
        errors++;
        $display("FAILED %0t: fetch enable %b expected %b", $time, cl_fetch_en_o,
                 fetch_ref);
      end
      // every enable bit takes both values
      wdata = ~wdata;
    end
    cl_eoc_i <= $random(seed);
    for (int i = 0; i < 2; i++) begin
      @(posedge clk_i);
      transact(`PERIPH_BASE + 24, 1'b0, '0, '0, rsp);
      lane_word.word    = '0;
      lane_word.lane[1] = {{(`PERIPH_DW - `N_CLUSTERS){1'b0}}, cl_eoc_i};
      expect_rsp(rsp, '{rdata: lane_word.word, err: 1'b0}, "EOC status read");
      cl_eoc_i <= ~cl_eoc_i;
    end

    // external window, reads and writes alike
    for (int i = 0; i < 8; i++) begin
      addr        = `EXT_BASE | ($random(seed) & 32'h7FFF_FFFC);
      wdata       = rand_word();
      strb        = $random(seed);
      exp_ext_req = '{addr: addr, we: i[0], wdata: wdata, strb: strb};
      transact(addr, i[0], wdata, strb, rsp);
      expect_rsp(rsp, ext_rule(addr), "external response");
    end

    // unmapped holes, then look for side effects
    // the write hole aliases L2 word 0 and the scratch lane
    transact(32'h0000_1008, 1'b1, rand_word(), '1, rsp);
    expect_rsp(rsp, '{rdata: '0, err: 1'b1}, "decode error write");
    transact(32'h1B00_0000, 1'b0, '0, '0, rsp);
    expect_rsp(rsp, '{rdata: '0, err: 1'b1}, "decode error read");
    transact(`L2_BASE, 1'b0, '0, '0, rsp);
    expect_rsp(rsp, '{rdata: l2_ref[0], err: 1'b0}, "L2 after decode error");
    transact(`PERIPH_BASE + 8, 1'b0, '0, '0, rsp);
    lane_word.word    = '0;
    lane_word.lane[1] = scratch_ref;
    expect_rsp(rsp, '{rdata: lane_word.word, err: 1'b0}, "scratch after decode error");

    repeat (4) @(posedge clk_i);
    $display("errors: %0d data, %0d assertion", errors, dut0.i_sva.fails);
    if (errors == 0 && dut0.i_sva.fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
design/soc_pkg.sv
design/soc_bus.sv
design/l2_mem.sv
design/soc_periph.sv
design/ext_mst_port.sv
design/pulp_soc.sv
bench/pulp_soc_sva.sv
bench/tb_pulp_soc.sv

// File: Makefile
TOP = tb_pulp_soc

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > run.log 2>&1 || true
	cat run.log
	grep -qx "sim passed" run.log

clean:
	rm -rf obj_dir run.log
